// ==== mem_subsys.f ====
source/mem_geom_pkg.sv
source/mem_types_pkg.sv
source/mem_access_if.sv
source/memory_ram.sv
source/memory_sp.sv
source/bist_engine.sv
source/mem_ctrl.sv
source/mem_subsys_top.sv
tb/tb_mem_subsys.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the memory subsystem testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --top-module tb_mem_subsys -f mem_subsys.f \
   -Mdir obj_dir -o sim_mem_subsys > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "verilator build failed"
   exit 1
fi

./obj_dir/sim_mem_subsys > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "SIMULATION FAILED" sim.log; then
   exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
   echo "simulation ended without a result line"
   exit 1
fi
exit 0

// ==== source/bist_engine.sv ====
/*
 * march self-test engine
 *   w0 up, r0w1 up, r1 down
 *   pipelined read compare, sticky fail flag
 *   busy level and done pulse
 */
`timescale 1ns/1ps

module bist_engine #(
   parameter int  dw    = mem_geom_pkg::DEF_DW,
   parameter int  depth = mem_geom_pkg::DEF_DEPTH,
   localparam int aw    = $clog2(depth)
) (
   input  logic            clk,
   input  logic            arst_n,
   input  logic            go,      // one-cycle start
   output logic            busy,
   output logic            done,    // one-cycle end marker
   output logic            fail,    // valid at done, held until next go
   mem_access_if.requester mem
);

   import mem_types_pkg::*;

   // 0101... with a one in bit 0
   function automatic logic [dw-1:0] alt_pattern();
      logic [dw-1:0] p;
      for (int i = 0; i < dw; i++) begin
         p[i] = ~i[0];
      end
      return p;
   endfunction

   localparam logic [dw-1:0] pattern   = alt_pattern();
   localparam logic [aw-1:0] last_addr = aw'(depth - 1);
   localparam int            max_len   = 4 * depth + 4;   // go to done, with slack

   march_phase_t  phase;
   logic [aw-1:0] addr;        // runs up or down
   logic          wr_half;     // second access of an r0w1 pair
   logic          rd_now;      // read issued this cycle
   logic          chk;         // read data arrives this cycle
   logic [dw-1:0] exp_data;    // expected value for chk

   //##################################################
   // access generation
   //##################################################

   assign rd_now   = busy && (phase == PH_R1 || (phase == PH_R0W1 && !wr_half));
   assign mem.en   = busy && phase != PH_END;
   assign mem.we   = phase == PH_W0 || (phase == PH_R0W1 && wr_half);
   assign mem.wem  = '1;                                  // full words only
   assign mem.addr = addr;
   assign mem.din  = (phase == PH_W0) ? pattern : ~pattern;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         busy    <= 1'b0;
         phase   <= PH_END;
         addr    <= '0;
         wr_half <= 1'b0;
      end else if (go) begin
         busy    <= 1'b1;
         phase   <= PH_W0;
         addr    <= '0;
         wr_half <= 1'b0;
      end else if (busy) begin
         unique case (phase)
            PH_W0: begin
               if (addr == last_addr) begin
                  phase <= PH_R0W1;
                  addr  <= '0;
               end else addr <= addr + 1'b1;
            end
            PH_R0W1: begin
               wr_half <= !wr_half;
               if (wr_half && addr == last_addr) begin
                  phase <= PH_R1;                         // turn around, top word first
               end else if (wr_half) addr <= addr + 1'b1;
            end
            PH_R1: begin
               if (addr == '0) phase <= PH_END;
               else addr <= addr - 1'b1;
            end
            PH_END: busy <= 1'b0;                         // last compare done this cycle
         endcase
      end
   end

   //##################################################
   // compare and status
   //##################################################

   always_ff @(posedge clk) begin
      exp_data <= (phase == PH_R1) ? ~pattern : pattern;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         chk  <= 1'b0;
         fail <= 1'b0;
         done <= 1'b0;
      end else begin
         chk  <= rd_now;
         done <= busy && phase == PH_END && !go;
         if (go) fail <= 1'b0;
         else if (chk && mem.dout != exp_data) fail <= 1'b1;   // sticky
      end
   end

   a_done_bound : assert property (@(posedge clk) disable iff (!arst_n)
      go |-> ##[1:max_len] done)
      else $error("self-test did not finish in time");

endmodule

// ==== source/mem_access_if.sv ====
/*
 * single-port access bundle
 *   enable, write, bit mask, address, write data, read data
 *   requester and target modports
 */
`timescale 1ns/1ps

interface mem_access_if #(
   parameter int dw    = mem_geom_pkg::DEF_DW,
   parameter int depth = mem_geom_pkg::DEF_DEPTH
);

   localparam int aw = $clog2(depth);

   logic          en;     // access this cycle
   logic          we;     // 1 write, 0 read
   logic [dw-1:0] wem;    // per-bit write mask
   logic [aw-1:0] addr;
   logic [dw-1:0] din;    // write data
   logic [dw-1:0] dout;   // read data, one cycle after a read

   modport requester (
      output en, we, wem, addr, din,
      input  dout
   );

   modport target (
      input  en, we, wem, addr, din,
      output dout
   );

endinterface

// ==== source/mem_ctrl.sv ====
/*
 * memory subsystem controller
 *   host request acceptance and read response pipeline
 *   self-test launch and hand-back
 *   shutdown hold
 */
`timescale 1ns/1ps

module mem_ctrl #(
   parameter int  dw    = mem_geom_pkg::DEF_DW,
   parameter int  depth = mem_geom_pkg::DEF_DEPTH,
   localparam int aw    = $clog2(depth)
) (
   input  logic                    clk,
   input  logic                    arst_n,
   input  logic                    req_valid,
   output logic                    req_ready,
   input  mem_types_pkg::mem_op_t  req_op,
   input  logic [aw-1:0]           req_addr,
   input  logic [dw-1:0]           req_wmask,
   input  logic [dw-1:0]           req_wdata,
   output logic                    rsp_valid,   // one cycle after a read accept
   output logic [dw-1:0]           rsp_data,
   input  logic                    bist_start,
   input  logic                    bist_busy,
   output logic                    bist_go,     // one-cycle launch
   input  logic                    shutdown,
   output logic                    test_sel,    // engine owns the array
   mem_access_if.requester         mem
);

   import mem_types_pkg::*;

   ctrl_state_t state;
   ctrl_state_t state_nxt;
   logic        accept;       // handshake this cycle
   logic        start_now;    // launch self-test this cycle

   //##################################################
   // host side
   //##################################################

   assign req_ready = (state == ST_IDLE || state == ST_HOST) && !shutdown;
   assign accept    = req_valid && req_ready;

   // memory acts on the accept edge
   assign mem.en   = accept;
   assign mem.we   = req_op == OP_WRITE;
   assign mem.wem  = req_wmask;
   assign mem.addr = req_addr;
   assign mem.din  = req_wdata;

   assign rsp_data = mem.dout;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) rsp_valid <= 1'b0;
      else rsp_valid <= accept && req_op == OP_READ;
   end

   //##################################################
   // ownership fsm
   //##################################################

   // a request taking the idle cycle wins, its response must not land in st_bist
   assign start_now = state == ST_IDLE && bist_start && !bist_busy && !shutdown && !accept;
   assign bist_go   = start_now;
   assign test_sel  = state == ST_BIST;

   always_comb begin
      state_nxt = state;
      unique case (state)
         ST_IDLE: begin
            if (start_now) state_nxt = ST_BIST;
            else if (accept) state_nxt = ST_HOST;
         end
         ST_HOST: if (!accept) state_nxt = ST_IDLE;   // response drains here
         ST_BIST: if (!bist_busy) state_nxt = ST_IDLE; // done pulse this cycle
         ST_OFF:  state_nxt = ST_IDLE;
      endcase
      if (shutdown) state_nxt = ST_OFF;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) state <= ST_OFF;                    // ready rises one cycle after release
      else state <= state_nxt;
   end

   a_no_rsp_bist : assert property (@(posedge clk) disable iff (!arst_n)
      state == ST_BIST |-> !rsp_valid)
      else $error("read response during self-test");

   // st_off keeps ready low for a cycle even when shutdown has just dropped
   a_no_ready_off : assert property (@(posedge clk) disable iff (!arst_n)
      shutdown |=> !req_ready)
      else $error("request ready right after shutdown");

endmodule

// ==== source/mem_geom_pkg.sv ====
/*
 * default memory geometry
 *   DEF_DW     word width in bits
 *   DEF_DEPTH  number of words in the array
 */

package mem_geom_pkg;

   //##################################################
   // geometry defaults
   //##################################################

   parameter int DEF_DW    = 32;   // bits per word
   parameter int DEF_DEPTH = 16;   // words, address width follows from this

endpackage

// ==== source/mem_subsys_top.sv ====
/*
 * memory subsystem top level
 *   controller, self-test engine, single-port wrapper
 *   functional and test access bundles
 */
`timescale 1ns/1ps

module mem_subsys_top #(
   parameter int  dw    = mem_geom_pkg::DEF_DW,
   parameter int  depth = mem_geom_pkg::DEF_DEPTH,
   localparam int aw    = $clog2(depth)
) (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   req_valid,
   output logic                   req_ready,
   input  mem_types_pkg::mem_op_t req_op,
   input  logic [aw-1:0]          req_addr,
   input  logic [dw-1:0]          req_wmask,
   input  logic [dw-1:0]          req_wdata,
   output logic                   rsp_valid,
   output logic [dw-1:0]          rsp_data,
   input  logic                   bist_start,
   output logic                   bist_done,
   output logic                   bist_fail,
   input  logic                   shutdown
);

   logic bist_go;
   logic bist_busy;
   logic test_sel;

   mem_access_if #(.dw(dw), .depth(depth)) func_if ();   // controller to wrapper
   mem_access_if #(.dw(dw), .depth(depth)) test_if ();   // engine to wrapper

   mem_ctrl #(.dw(dw), .depth(depth)) u_ctrl (
      .clk        (clk),
      .arst_n     (arst_n),
      .req_valid  (req_valid),
      .req_ready  (req_ready),
      .req_op     (req_op),
      .req_addr   (req_addr),
      .req_wmask  (req_wmask),
      .req_wdata  (req_wdata),
      .rsp_valid  (rsp_valid),
      .rsp_data   (rsp_data),
      .bist_start (bist_start),
      .bist_busy  (bist_busy),
      .bist_go    (bist_go),
      .shutdown   (shutdown),
      .test_sel   (test_sel),
      .mem        (func_if)
   );

   bist_engine #(.dw(dw), .depth(depth)) u_bist (
      .clk    (clk),
      .arst_n (arst_n),
      .go     (bist_go),
      .busy   (bist_busy),
      .done   (bist_done),
      .fail   (bist_fail),
      .mem    (test_if)
   );

   memory_sp #(.dw(dw), .depth(depth)) u_mem (
      .clk      (clk),
      .shutdown (shutdown),
      .test_sel (test_sel),
      .func     (func_if),
      .test     (test_if)
   );

endmodule

// ==== source/mem_types_pkg.sv ====
/*
 * type definitions for the memory subsystem
 *   mem_op_t       host access opcode
 *   ctrl_state_t   controller states
 *   march_phase_t  self-test phases
 */

package mem_types_pkg;

   typedef enum logic {
      OP_READ  = 1'b0,        // returns data one cycle later
      OP_WRITE = 1'b1         // masked write, no response
   } mem_op_t;

   typedef enum logic [1:0] {
      ST_IDLE = 2'd0,         // host may start, or self-test may launch
      ST_HOST = 2'd1,         // host traffic streaming
      ST_BIST = 2'd2,         // engine owns the array
      ST_OFF  = 2'd3          // shutdown, also the reset state
   } ctrl_state_t;

   typedef enum logic [1:0] {
      PH_W0   = 2'd0,         // up, write pattern
      PH_R0W1 = 2'd1,         // up, read pattern then write inverse
      PH_R1   = 2'd2,         // down, read inverse
      PH_END  = 2'd3          // last compare drains
   } march_phase_t;

endpackage

// ==== source/memory_ram.sv ====
/*
 * behavioural array standing in for the sram macro
 *   masked write port
 *   registered read port holding its last value when idle
 */
`timescale 1ns/1ps

module memory_ram #(
   parameter int  dw    = mem_geom_pkg::DEF_DW,
   parameter int  depth = mem_geom_pkg::DEF_DEPTH,
   localparam int aw    = $clog2(depth)
) (
   input  logic          clk,
   input  logic          rd_en,     // read strobe
   input  logic [aw-1:0] rd_addr,
   output logic [dw-1:0] rd_data,   // valid the cycle after rd_en
   input  logic          wr_en,     // write strobe
   input  logic [aw-1:0] wr_addr,
   input  logic [dw-1:0] wr_mask,   // 1 = bit is written
   input  logic [dw-1:0] wr_data
);

   logic [dw-1:0] ram [depth];      // storage, no reset

   //##################################################
   // write port
   //##################################################

   always_ff @(posedge clk) begin
      if (wr_en) begin
         // unmasked bits keep their old value
         ram[wr_addr] <= (ram[wr_addr] & ~wr_mask) | (wr_data & wr_mask);
      end
   end

   //##################################################
   // read port
   //##################################################

   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_data <= ram[rd_addr];   // holds when rd_en low
      end
   end

endmodule

// ==== source/memory_sp.sv ====
/*
 * single-port wrapper
 *   functional / test port select
 *   shutdown gating of access and read data
 *   split into read and write strobes for the array
 */
`timescale 1ns/1ps

module memory_sp #(
   parameter int  dw    = mem_geom_pkg::DEF_DW,
   parameter int  depth = mem_geom_pkg::DEF_DEPTH,
   localparam int aw    = $clog2(depth)
) (
   input  logic          clk,
   input  logic          shutdown,   // from always-on domain
   input  logic          test_sel,   // 1 = self-test owns the array
   mem_access_if.target  func,
   mem_access_if.target  test
);

   logic          en;
   logic          we;
   logic [dw-1:0] wem;
   logic [aw-1:0] addr;
   logic [dw-1:0] din;
   logic [dw-1:0] rd_data;
   logic [dw-1:0] dout;

   // port select
   assign en   = test_sel ? test.en   : func.en;
   assign we   = test_sel ? test.we   : func.we;
   assign wem  = test_sel ? test.wem  : func.wem;
   assign addr = test_sel ? test.addr : func.addr;
   assign din  = test_sel ? test.din  : func.din;

   memory_ram #(
      .dw    (dw),
      .depth (depth)
   ) u_ram (
      .clk     (clk),
      .rd_en   (en & ~we & ~shutdown),   // reads blocked in shutdown
      .rd_addr (addr),
      .rd_data (rd_data),
      .wr_en   (en & we & ~shutdown),    // array contents retained
      .wr_addr (addr),
      .wr_mask (wem),
      .wr_data (din)
   );

   assign dout      = shutdown ? '0 : rd_data;   // quiet output while off
   assign func.dout = dout;
   assign test.dout = dout;

   // the controller must already hold off host traffic in shutdown
   a_no_access_off : assert property (@(posedge clk)
      shutdown |-> !func.en)
      else $error("memory access enabled during shutdown");

endmodule

// ==== tb/tb_mem_subsys.sv ====
/*
 * testbench for the memory subsystem
 *   clock, reset and stimulus table
 *   shadow model of the array with masked writes
 *   data and flag compare tasks, watchdog
 */
`timescale 1ns/1ps

module tb_mem_subsys;

   import mem_geom_pkg::*;
   import mem_types_pkg::*;

   localparam int dw     = DEF_DW;
   localparam int depth  = DEF_DEPTH;
   localparam int aw     = $clog2(depth);
   localparam int n_rows = 16;
   localparam logic [dw-1:0] pattern = {(dw/2){2'b01}};   // one in bit 0

   typedef enum {
      ROW_WRITE,        // masked host write
      ROW_READ,         // single read, checked against shadow
      ROW_READ_PAIR,    // two reads on consecutive edges
      ROW_BIST,         // self-test, then read every word
      ROW_BIST_HOLD,    // self-test with a read held against it
      ROW_OFF           // shutdown pulse with a write offered
   } row_kind_t;

   logic          clk;
   logic          arst_n;
   logic          req_valid;
   logic          req_ready;
   mem_op_t       req_op;
   logic [aw-1:0] req_addr;
   logic [dw-1:0] req_wmask;
   logic [dw-1:0] req_wdata;
   logic          rsp_valid;
   logic [dw-1:0] rsp_data;
   logic          bist_start;
   logic          bist_done;
   logic          bist_fail;
   logic          shutdown;

   logic [dw-1:0] shadow [depth];      // expected array contents
   string         row_name [n_rows];
   row_kind_t     row_kind [n_rows];
   int            row_addr [n_rows];
   logic [dw-1:0] row_mask [n_rows];
   logic [dw-1:0] row_data [n_rows];
   logic          row_exp  [n_rows];   // expected bist_fail
   int            n_added;
   int            n_checks;
   int            n_errors;

   mem_subsys_top #(
      .dw    (dw),
      .depth (depth)
   ) dut (
      .clk        (clk),
      .arst_n     (arst_n),
      .req_valid  (req_valid),
      .req_ready  (req_ready),
      .req_op     (req_op),
      .req_addr   (req_addr),
      .req_wmask  (req_wmask),
      .req_wdata  (req_wdata),
      .rsp_valid  (rsp_valid),
      .rsp_data   (rsp_data),
      .bist_start (bist_start),
      .bist_done  (bist_done),
      .bist_fail  (bist_fail),
      .shutdown   (shutdown)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;           // 20 ns period
   end

   // self-test rows take about 4 * depth cycles each
   initial begin
      repeat (n_rows * 4 * depth + 400) @(posedge clk);
      $display("watchdog expired, the run hung");
      $display("SIMULATION FAILED");
      $finish;
   end

   //##################################################
   // compare tasks
   //##################################################

   task automatic check_data(input string name, input logic [dw-1:0] exp,
                             input logic [dw-1:0] act);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      end else begin
         $display("ok  %s  %h", name, act);
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("CHECK FAILED %s expected %b actual %b", name, exp, act);
      end else begin
         $display("ok  %s  %b", name, act);
      end
   endtask

   //##################################################
   // stimulus table
   //##################################################

   task automatic add_row(input string name, input row_kind_t kind, input int a,
                          input logic [dw-1:0] m, input logic [dw-1:0] d, input logic e);
      row_name[n_added] = name;
      row_kind[n_added] = kind;
      row_addr[n_added] = a;
      row_mask[n_added] = m;
      row_data[n_added] = d;
      row_exp[n_added]  = e;
      n_added++;
   endtask

   task automatic build_table();
      add_row("write word 0", ROW_WRITE, 0, '1, $urandom(), 1'b0);
      add_row("write word 1", ROW_WRITE, 1, '1, $urandom(), 1'b0);
      add_row("write word 5", ROW_WRITE, 5, '1, $urandom(), 1'b0);
      add_row("read word 0", ROW_READ, 0, '0, '0, 1'b0);
      add_row("read word 5", ROW_READ, 5, '0, '0, 1'b0);
      add_row("masked write word 1", ROW_WRITE, 1, 32'h00ff_0f0f, $urandom(), 1'b0);
      add_row("read masked word 1", ROW_READ, 1, '0, '0, 1'b0);
      add_row("read pair 0 1", ROW_READ_PAIR, 0, '0, '0, 1'b0);
      add_row("self-test", ROW_BIST, 0, '0, '0, 1'b0);
      add_row("write word 3", ROW_WRITE, 3, '1, $urandom(), 1'b0);
      add_row("masked write word 3", ROW_WRITE, 3, 32'hf0f0_0000, $urandom(), 1'b0);
      add_row("self-test held read", ROW_BIST_HOLD, 3, '0, '0, 1'b0);
      add_row("write word 7", ROW_WRITE, 7, '1, $urandom(), 1'b0);
      add_row("shutdown", ROW_OFF, 7, '1, $urandom(), 1'b0);
      add_row("read word 7", ROW_READ, 7, '0, '0, 1'b0);
      add_row("read pair 14 15", ROW_READ_PAIR, 14, '0, '0, 1'b0);
   endtask

   //##################################################
   // host side tasks
   //##################################################

   // ready only depends on state and shutdown, stable at the falling edge
   task automatic wait_accept();
      while (!req_ready) @(negedge clk);
      @(posedge clk);                   // accept edge
      @(negedge clk);
      req_valid = 1'b0;
   endtask

   task automatic host_access(input mem_op_t op, input int a,
                              input logic [dw-1:0] m, input logic [dw-1:0] d);
      @(negedge clk);
      req_valid = 1'b1;
      req_op    = op;
      req_addr  = aw'(a);
      req_wmask = m;
      req_wdata = d;
      wait_accept();
   endtask

   task automatic write_word(input string name, input int a,
                             input logic [dw-1:0] m, input logic [dw-1:0] d);
      host_access(OP_WRITE, a, m, d);
      for (int i = 0; i < dw; i++) begin
         if (m[i]) shadow[a][i] = d[i];   // masked bits only
      end
      check_flag({name, " no response"}, 1'b0, rsp_valid);
   endtask

   task automatic read_word(input string name, input int a);
      host_access(OP_READ, a, '0, '0);
      check_flag({name, " rsp_valid"}, 1'b1, rsp_valid);
      check_data(name, shadow[a], rsp_data);
      @(negedge clk);
      check_flag({name, " rsp pulse ends"}, 1'b0, rsp_valid);
   endtask

   task automatic read_pair(input string name, input int a);
      @(negedge clk);
      req_valid = 1'b1;
      req_op    = OP_READ;
      req_addr  = aw'(a);
      while (!req_ready) @(negedge clk);
      @(posedge clk);                   // first accept
      @(negedge clk);
      check_flag({name, " first rsp_valid"}, 1'b1, rsp_valid);
      check_data({name, " first"}, shadow[a], rsp_data);
      check_flag({name, " ready for second"}, 1'b1, req_ready);
      req_addr = aw'(a + 1);
      @(posedge clk);                   // second accept, next edge
      @(negedge clk);
      req_valid = 1'b0;
      check_flag({name, " second rsp_valid"}, 1'b1, rsp_valid);
      check_data({name, " second"}, shadow[a + 1], rsp_data);
      @(negedge clk);
      check_flag({name, " rsp ends"}, 1'b0, rsp_valid);
   endtask

   task automatic self_test(input string name, input logic fail_exp, input logic hold,
                            input int a);
      logic early;
      early = 1'b0;
      @(negedge clk);
      bist_start = 1'b1;
      do begin
         @(negedge clk);
      end while (req_ready);            // ready drops once launched
      bist_start = 1'b0;
      if (hold) begin
         req_valid = 1'b1;              // held against the running test
         req_op    = OP_READ;
         req_addr  = aw'(a);
      end
      do begin
         @(negedge clk);
         if (hold && req_ready) early = 1'b1;
      end while (!bist_done);
      check_flag({name, " fail"}, fail_exp, bist_fail);
      for (int i = 0; i < depth; i++) begin
         shadow[i] = ~pattern;          // r0w1 leaves the inverse behind
      end
      if (hold) begin
         check_flag({name, " held until done"}, 1'b0, early);
         wait_accept();
         check_flag({name, " held rsp_valid"}, 1'b1, rsp_valid);
         check_data({name, " held read"}, shadow[a], rsp_data);
      end
      for (int i = 0; i < depth; i++) begin
         read_word($sformatf("%s word %0d", name, i), i);
      end
   endtask

   task automatic shutdown_hold(input string name, input int a, input logic [dw-1:0] d);
      logic leaked;
      leaked = 1'b0;
      @(negedge clk);
      shutdown  = 1'b1;
      req_valid = 1'b1;                 // write offered while off
      req_op    = OP_WRITE;
      req_addr  = aw'(a);
      req_wmask = '1;
      req_wdata = d;
      repeat (6) begin
         @(negedge clk);
         if (req_ready) leaked = 1'b1;
      end
      check_flag({name, " ready held low"}, 1'b0, leaked);
      check_data({name, " dout quiet"}, '0, rsp_data);
      req_valid = 1'b0;
      shutdown  = 1'b0;
   endtask

   //##################################################
   // main sequence
   //##################################################

   initial begin
      void'($urandom(77362));           // one seed for the whole run
      n_added    = 0;
      n_checks   = 0;
      n_errors   = 0;
      arst_n     = 1'b0;
      req_valid  = 1'b0;
      req_op     = OP_READ;
      req_addr   = '0;
      req_wmask  = '0;
      req_wdata  = '0;
      bist_start = 1'b0;
      shutdown   = 1'b0;
      build_table();
      repeat (5) @(posedge clk);
      @(negedge clk);
      check_flag("reset req_ready", 1'b0, req_ready);
      check_flag("reset rsp_valid", 1'b0, rsp_valid);
      check_flag("reset bist_done", 1'b0, bist_done);
      check_flag("reset bist_fail", 1'b0, bist_fail);
      arst_n = 1'b1;
      @(negedge clk);
      check_flag("ready after reset", 1'b1, req_ready);
      for (int r = 0; r < n_rows; r++) begin
         case (row_kind[r])
            ROW_WRITE:     write_word(row_name[r], row_addr[r], row_mask[r], row_data[r]);
            ROW_READ:      read_word(row_name[r], row_addr[r]);
            ROW_READ_PAIR: read_pair(row_name[r], row_addr[r]);
            ROW_BIST:      self_test(row_name[r], row_exp[r], 1'b0, row_addr[r]);
            ROW_BIST_HOLD: self_test(row_name[r], row_exp[r], 1'b1, row_addr[r]);
            ROW_OFF:       shutdown_hold(row_name[r], row_addr[r], row_data[r]);
         endcase
      end
      repeat (2) @(negedge clk);
      $display("%0d checks, %0d failed", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule
